// File: Bender.yml
package:
  name: mem_subsys

sources:
  # RTL, package first
  - files:
      - hdl/mem_pkg.sv
      - hdl/line_arbiter.sv
      - hdl/line_burst_adaptor.sv
      - hdl/mem_subsys.sv
  # testbench and bound assertions
  - target: test
    files:
      - bench/mem_subsys_sva.sv
      - bench/tb_mem_subsys.sv

// File: bench/mem_subsys_sva.sv
`timescale 1ns/1ps

// protocol checks, one copy in the arbiter and one in the adaptor
module mem_subsys_sva (
    input logic clk,
    input logic rst,
    input logic read_i,
    input logic write_i,
    input logic first_resp_i,
    input logic second_resp_i
);

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // a transfer is a read or a write, never both
    assert property (@(posedge clk) disable iff (rst) !(read_i && write_i))
        else begin
            $error("read and write high together");
            fail_count++;
        end

    // response pulses last exactly one cycle
    assert property (@(posedge clk) disable iff (rst) first_resp_i |=> !first_resp_i)
        else begin
            $error("first response wider than one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) second_resp_i |=> !second_resp_i)
        else begin
            $error("second response wider than one cycle");
            fail_count++;
        end

    // one side answered per cycle
    assert property (@(posedge clk) disable iff (rst) !(first_resp_i && second_resp_i))
        else begin
            $error("both responses high together");
            fail_count++;
        end

endmodule

// arbiter: forwarded request and both cache responses
bind line_arbiter mem_subsys_sva arb_sva_i (
    .clk           (clk),
    .rst           (rst),
    .read_i        (mem_req_o.read),
    .write_i       (mem_req_o.write),
    .first_resp_i  (icache_resp_o),
    .second_resp_i (dcache_resp_o)
);

// adaptor: burst read and write, its resp against the start of a transfer
bind line_burst_adaptor mem_subsys_sva adaptor_sva_i (
    .clk           (clk),
    .rst           (rst),
    .read_i        (bmem_read_o),
    .write_i       (bmem_write_o),
    .first_resp_i  (resp_o),
    .second_resp_i (start)
);

// File: bench/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 8;
    // 6 tests, up to 8 transactions each, 20 cycles per transaction
    localparam int WATCHDOG_NS = 6 * 8 * 20 * CLK_PERIOD;
    localparam int RESP_LIMIT  = 40;

    logic      clk;
    logic      rst;
    line_req_t icache_req_i;
    line_req_t dcache_req_i;
    logic      icache_resp_o;
    logic      dcache_resp_o;
    line_t     icache_rdata_o;
    line_t     dcache_rdata_o;
    addr_t     bmem_address_o;
    logic      bmem_read_o;
    logic      bmem_write_o;
    beat_t     bmem_wdata_o;
    beat_t     bmem_rdata_i;
    logic      bmem_resp_i;

    // sparse line store, untouched lines read a fill pattern
    line_t       mem_lines [addr_t];
    logic [31:0] lfsr_q = 32'h219e;
    int          error_count = 0;
    int          failed_tests = 0;
    int          icache_resps = 0;
    int          dcache_resps = 0;

    mem_subsys mem_subsys_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    function automatic line_t random_line();
        line_t val;
        for (int w = 0; w < 8; w++) begin
            val[w*32 +: 32] = lfsr_bits(32);
        end
        return val;
    endfunction

    // every word mixes in the whole line address
    function automatic line_t fill_line(input addr_t addr);
        line_t val;
        for (int w = 0; w < 8; w++) begin
            val[w*32 +: 32] = addr ^ (32'h9e37_79b9 * (w + 1));
        end
        return val;
    endfunction

    function automatic line_t stored_line(input addr_t addr);
        return mem_lines.exists(addr) ? mem_lines[addr] : fill_line(addr);
    endfunction

    function automatic line_req_t make_req(input logic write, input addr_t addr,
                                           input line_t wdata);
        return '{read: !write, write: write, addr: addr, wdata: wdata};
    endfunction

    task automatic check_line(input string name, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_resp(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    // burst memory, looks at the bus 1 ns after the edge, answers at 2 ns
    initial begin : burst_memory
        addr_t addr;
        line_t val;
        logic  is_write;
        bmem_resp_i  = 1'b0;
        bmem_rdata_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (bmem_read_o || bmem_write_o)) begin
                addr     = bmem_address_o;
                is_write = bmem_write_o;
                val      = stored_line(addr);
                // 0 to 3 stall cycles before the first beat
                repeat (lfsr_bits(2)) begin
                    @(posedge clk);
                    #1;
                end
                // beat k sits at line bits 64k upward
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    if (is_write) begin
                        val[k*BEAT_W +: BEAT_W] = bmem_wdata_o;
                    end
                    #1;
                    bmem_resp_i  = 1'b1;
                    bmem_rdata_i = is_write ? '0 : val[k*BEAT_W +: BEAT_W];
                    @(posedge clk);
                    #1;
                end
                #1;
                bmem_resp_i  = 1'b0;
                bmem_rdata_i = '0;
                if (is_write) begin
                    mem_lines[addr] = val;
                end
            end
        end
    end

    // counts every response pulse, flags overlaps
    initial begin : resp_monitor
        forever begin
            @(negedge clk);
            if (!rst) begin
                icache_resps += (icache_resp_o === 1'b1);
                dcache_resps += (dcache_resp_o === 1'b1);
                if (icache_resp_o === 1'b1 && dcache_resp_o === 1'b1) begin
                    $display("both cache responses high at %0t ns", $time);
                    error_count++;
                end
                if (bmem_read_o === 1'b1 && bmem_write_o === 1'b1) begin
                    $display("burst read and write high together at %0t ns", $time);
                    error_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, tests still running after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic reset_dut();
        @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // a zero request drops the port
    task automatic issue_req(input logic use_dcache, input line_req_t req);
        @(posedge clk);
        #2;
        if (use_dcache) begin
            dcache_req_i = req;
        end else begin
            icache_req_i = req;
        end
    endtask

    task automatic wait_resp(input logic use_dcache, output line_t rdata, output logic seen);
        int cycles;
        seen   = 1'b0;
        rdata  = '0;
        cycles = 0;
        while (!seen && cycles < RESP_LIMIT) begin
            @(negedge clk);
            if ((use_dcache ? dcache_resp_o : icache_resp_o) === 1'b1) begin
                seen  = 1'b1;
                rdata = use_dcache ? dcache_rdata_o : icache_rdata_o;
            end
            cycles++;
        end
        if (!seen) begin
            $display("no %s response within %0d cycles",
                     use_dcache ? "data" : "instruction", RESP_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_line(input logic use_dcache, input line_req_t req, output line_t rdata);
        logic seen;
        issue_req(use_dcache, req);
        wait_resp(use_dcache, rdata, seen);
        issue_req(use_dcache, '0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errs_before);
            failed_tests++;
        end
    endtask

    // preloaded line, then an unaligned fetch of a filled line
    task automatic instr_line_read();
        int    errs;
        line_t expected;
        line_t rdata;
        errs     = error_count;
        expected = random_line();
        mem_lines[32'h0000_1a40] = expected;
        run_line(1'b0, make_req(1'b0, 32'h0000_1a40, '0), rdata);
        check_line("icache_rdata_o", rdata, expected);
        run_line(1'b0, make_req(1'b0, 32'h0000_2f74, '0), rdata);
        check_line("icache_rdata_o", rdata, fill_line(32'h0000_2f60));
        report_test("instruction line read", errs);
    endtask

    task automatic data_write_read();
        int    errs;
        line_t wline;
        line_t rdata;
        errs  = error_count;
        wline = random_line();
        run_line(1'b1, make_req(1'b1, 32'h0004_0080, wline), rdata);
        check_line("mem_lines", stored_line(32'h0004_0080), wline);
        run_line(1'b1, make_req(1'b0, 32'h0004_0080, '0), rdata);
        check_line("dcache_rdata_o", rdata, wline);
        report_test("data write then read", errs);
    endtask

    // data side wins, instruction side follows
    task automatic both_caches_contend();
        int    errs;
        int    icount;
        int    dcount;
        line_t iline;
        line_t dline;
        line_t rdata;
        logic  seen;
        errs   = error_count;
        icount = icache_resps;
        dcount = dcache_resps;
        iline  = random_line();
        dline  = random_line();
        mem_lines[32'h0000_0400] = iline;
        mem_lines[32'h0001_0400] = dline;
        @(posedge clk);
        #2;
        icache_req_i = make_req(1'b0, 32'h0000_0400, '0);
        dcache_req_i = make_req(1'b0, 32'h0001_0400, '0);
        wait_resp(1'b1, rdata, seen);
        check_resp("icache_resp_o", icache_resp_o, 1'b0);
        check_line("dcache_rdata_o", rdata, dline);
        issue_req(1'b1, '0);
        if (icache_resps != icount) begin
            $display("instruction response came before the data response");
            error_count++;
        end
        wait_resp(1'b0, rdata, seen);
        check_resp("dcache_resp_o", dcache_resp_o, 1'b0);
        check_line("icache_rdata_o", rdata, iline);
        issue_req(1'b0, '0);
        repeat (4) @(posedge clk);
        if (icache_resps != icount + 1 || dcache_resps != dcount + 1) begin
            $display("contention gave %0d instruction and %0d data responses, not one each",
                     icache_resps - icount, dcache_resps - dcount);
            error_count++;
        end
        report_test("both caches at once", errs);
    endtask

    // next fetch goes out in the cycle after each response
    task automatic back_to_back_fetch();
        int    errs;
        int    icount;
        line_t rdata;
        logic  seen;
        errs   = error_count;
        icount = icache_resps;
        issue_req(1'b0, make_req(1'b0, 32'h0000_8000, '0));
        for (int i = 0; i < 4; i++) begin
            wait_resp(1'b0, rdata, seen);
            check_line("icache_rdata_o", rdata, fill_line(32'h0000_8000 + 32 * i));
            if (i < 3) begin
                issue_req(1'b0, make_req(1'b0, 32'h0000_8000 + 32 * (i + 1), '0));
            end else begin
                issue_req(1'b0, '0);
            end
        end
        repeat (4) @(posedge clk);
        if (icache_resps != icount + 4) begin
            $display("four fetches got %0d responses", icache_resps - icount);
            error_count++;
        end
        report_test("back to back fetches", errs);
    endtask

    task automatic random_write_read();
        int    errs;
        addr_t addr;
        line_t wline;
        line_t rdata;
        errs = error_count;
        for (int p = 0; p < 4; p++) begin
            addr  = lfsr_bits(27) << 5;
            wline = random_line();
            run_line(1'b1, make_req(1'b1, addr, wline), rdata);
            run_line(1'b1, make_req(1'b0, addr, '0), rdata);
            check_line("dcache_rdata_o", rdata, wline);
        end
        report_test("random write read pairs", errs);
    endtask

    task automatic idle_after_reset();
        int errs;
        errs = error_count;
        reset_dut();
        repeat (20) begin
            @(negedge clk);
            check_resp("icache_resp_o", icache_resp_o, 1'b0);
            check_resp("dcache_resp_o", dcache_resp_o, 1'b0);
            check_resp("bmem_read_o", bmem_read_o, 1'b0);
            check_resp("bmem_write_o", bmem_write_o, 1'b0);
        end
        report_test("idle after reset", errs);
    endtask

    initial begin : run_tests
        rst          = 1'b1;
        icache_req_i = '0;
        dcache_req_i = '0;
        reset_dut();
        instr_line_read();
        data_write_read();
        both_caches_contend();
        back_to_back_fetch();
        random_write_read();
        idle_after_reset();
        // failures of the bound protocol checkers
        error_count += mem_subsys_i.line_arbiter_i.arb_sva_i.fail_count;
        error_count += mem_subsys_i.line_burst_adaptor_i.adaptor_sva_i.fail_count;
        $display("tests run: 6, failed: %0d, errors: %0d", failed_tests, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/mem_pkg.sv
hdl/line_arbiter.sv
hdl/line_burst_adaptor.sv
hdl/mem_subsys.sv
bench/mem_subsys_sva.sv
bench/tb_mem_subsys.sv

// File: hdl/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter (
    input  logic                clk,
    input  logic                rst,

    // instruction cache side
    input  mem_pkg::line_req_t  icache_req_i,
    output logic                icache_resp_o,
    output mem_pkg::line_t      icache_rdata_o,

    // data cache side
    input  mem_pkg::line_req_t  dcache_req_i,
    output logic                dcache_resp_o,
    output mem_pkg::line_t      dcache_rdata_o,

    // towards the burst adaptor
    output mem_pkg::line_req_t  mem_req_o,
    input  logic                mem_resp_i,
    input  mem_pkg::line_t      mem_rdata_i
);

    import mem_pkg::*;

    // idle -> serving until adaptor resp -> one recover cycle -> idle
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE,
        ARB_RECOVER
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;

    // one-hot record of the winner, both low when nobody owns the port
    logic grant_icache_q;
    logic grant_icache_d;
    logic grant_dcache_q;
    logic grant_dcache_d;

    logic serving;

    assign serving = (state_q == ARB_SERVE);

    always_comb begin
        state_d        = state_q;
        grant_icache_d = grant_icache_q;
        grant_dcache_d = grant_dcache_q;

        unique case (state_q)
            ARB_IDLE: begin
                // data cache has priority when both ask together
                if (req_active(dcache_req_i)) begin
                    state_d        = ARB_SERVE;
                    grant_dcache_d = 1'b1;
                end else if (req_active(icache_req_i)) begin
                    state_d        = ARB_SERVE;
                    grant_icache_d = 1'b1;
                end
            end
            ARB_SERVE: begin
                // grant held until the line comes back
                if (mem_resp_i) begin
                    state_d        = ARB_RECOVER;
                    grant_icache_d = 1'b0;
                    grant_dcache_d = 1'b0;
                end
            end
            ARB_RECOVER: begin
                // winner drops its request here, so it is not seen twice
                state_d = ARB_IDLE;
            end
            default: begin
                state_d        = ARB_IDLE;
                grant_icache_d = 1'b0;
                grant_dcache_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= ARB_IDLE;
            grant_icache_q <= 1'b0;
            grant_dcache_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            grant_icache_q <= grant_icache_d;
            grant_dcache_q <= grant_dcache_d;
        end
    end

    // forward the granted request as is
    // nothing leaves outside the serving state
    always_comb begin
        mem_req_o = '0;
        if (serving && grant_dcache_q) begin
            mem_req_o = dcache_req_i;
        end else if (serving && grant_icache_q) begin
            mem_req_o = icache_req_i;
        end
    end

    // response pulse passes straight through to the winner only
    assign icache_resp_o = mem_resp_i & serving & grant_icache_q;
    assign dcache_resp_o = mem_resp_i & serving & grant_dcache_q;

    // line steered the same way, loser sees zeros
    assign icache_rdata_o = grant_icache_q ? mem_rdata_i : '0;
    assign dcache_rdata_o = grant_dcache_q ? mem_rdata_i : '0;

endmodule

// File: hdl/line_burst_adaptor.sv
`timescale 1ns/1ps

module line_burst_adaptor (
    input  logic                clk,
    input  logic                rst,

    // line side, from the arbiter
    input  mem_pkg::line_req_t  req_i,
    output logic                resp_o,
    output mem_pkg::line_t      rdata_o,

    // burst memory side
    output mem_pkg::addr_t      bmem_address_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_resp_i
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_READ,
        AD_WRITE,
        AD_DONE
    } ad_state_t;

    ad_state_t state_q;
    ad_state_t state_d;

    // beat currently on the bus
    beat_idx_t beat_q;
    beat_idx_t beat_d;

    // line buffer and the latched line address
    line_t line_q;
    addr_t addr_q;

    logic start;
    logic last_beat;
    logic beat_done;

    // a new transfer is only taken from idle
    assign start = (state_q == AD_IDLE) && req_active(req_i);

    assign last_beat = (beat_q == beat_idx_t'(BEATS_PER_LINE - 1));

    // memory accepted or delivered one beat this cycle
    assign beat_done = bmem_resp_i && ((state_q == AD_READ) || (state_q == AD_WRITE));

    always_comb begin
        state_d = state_q;
        beat_d  = beat_q;

        unique case (state_q)
            AD_IDLE: begin
                beat_d = '0;
                // write before read, the two never come together
                if (req_i.write) begin
                    state_d = AD_WRITE;
                end else if (req_i.read) begin
                    state_d = AD_READ;
                end
            end
            AD_READ, AD_WRITE: begin
                // memory may stall before the first beat
                // after that beats come back to back
                if (bmem_resp_i) begin
                    beat_d = beat_q + 1'b1;
                    if (last_beat) begin
                        state_d = AD_DONE;
                    end
                end
            end
            AD_DONE: begin
                // resp pulse cycle
                state_d = AD_IDLE;
            end
            default: begin
                state_d = AD_IDLE;
                beat_d  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= AD_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= line_base(req_i.addr);
            // write line kept whole, beats picked out later
            if (req_i.write) begin
                line_q <= req_i.wdata;
            end
        end else if (beat_done && (state_q == AD_READ)) begin
            // beat k lands at line bits 64k upward
            line_q[beat_q*BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

    // burst request held level until the memory finishes
    assign bmem_read_o    = (state_q == AD_READ);
    assign bmem_write_o   = (state_q == AD_WRITE);
    assign bmem_address_o = addr_q;

    // beat 0 shows as soon as write goes high, next one after each resp
    assign bmem_wdata_o = line_q[beat_q*BEAT_W +: BEAT_W];

    // one cycle after the fourth beat
    assign resp_o  = (state_q == AD_DONE);
    assign rdata_o = line_q;

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

    // widths fixed by the burst bus and the cache line size
    localparam int ADDR_W         = 32;
    localparam int LINE_W         = 256;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = 4;

    // 32-byte lines, low address bits pick a byte inside the line
    localparam int OFFSET_W = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BEAT_W-1:0] beat_t;

    // counts beats 0 to 3 inside one burst
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    // one cache line request, held as a level until the response pulse
    // icache keeps write low
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        line_t wdata;
    } line_req_t;

    // true while a requester asks for a transfer
    function automatic logic req_active(input line_req_t req);
        return req.read | req.write;
    endfunction

    // strip the byte offset, memory works on whole lines
    function automatic addr_t line_base(input addr_t addr);
        addr_t base;
        base = addr;
        base[OFFSET_W-1:0] = '0;
        return base;
    endfunction

endpackage

// File: hdl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic                clk,
    input  logic                rst,

    // instruction cache physical memory port
    input  mem_pkg::line_req_t  icache_req_i,
    output logic                icache_resp_o,
    output mem_pkg::line_t      icache_rdata_o,

    // data cache physical memory port
    input  mem_pkg::line_req_t  dcache_req_i,
    output logic                dcache_resp_o,
    output mem_pkg::line_t      dcache_rdata_o,

    // shared burst memory port
    output mem_pkg::addr_t      bmem_address_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_resp_i
);

    import mem_pkg::*;

    // granted request and its answer between arbiter and adaptor
    line_req_t arb_req;
    logic      arb_resp;
    line_t     arb_rdata;

    // picks one cache at a time
    line_arbiter line_arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .icache_req_i   (icache_req_i),
        .icache_resp_o  (icache_resp_o),
        .icache_rdata_o (icache_rdata_o),
        .dcache_req_i   (dcache_req_i),
        .dcache_resp_o  (dcache_resp_o),
        .dcache_rdata_o (dcache_rdata_o),
        .mem_req_o      (arb_req),
        .mem_resp_i     (arb_resp),
        .mem_rdata_i    (arb_rdata)
    );

    // line to four-beat burst and back
    line_burst_adaptor line_burst_adaptor_i (
        .clk            (clk),
        .rst            (rst),
        .req_i          (arb_req),
        .resp_o         (arb_resp),
        .rdata_o        (arb_rdata),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule
